/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := dram_th_tb
FILELIST  := vlog.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "test failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

/* source/dram_test_h_wb.sv */
`default_nettype none
`timescale 1ns/1ps

module dram_test_h_wb (
  input  logic                          wb_clk_i,
  input  logic                          wb_rst_i,
  input  logic                          wb_we_i,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic [1:0]                    wb_sel_i,
  input  logic [31:0]                   wb_adr_i,
  input  dram_th_regs_pkg::wb_data_t    wb_dat_i,
  output dram_th_regs_pkg::wb_data_t    wb_dat_o,
  output logic                          wb_ack_o,
  output logic [3:0]                    status_addr_o,
  input  dram_th_regs_pkg::wb_data_t    harness_status_i,
  output dram_th_regs_pkg::ctrl_word_t  harness_control_o
);

  dram_th_regs_pkg::wb_word_adr_t adr_q;
  dram_th_regs_pkg::wb_word_adr_t adr_in;
  dram_th_regs_pkg::ctrl_word_t   ctrl_q;
  logic                           ack_q;
  logic                           take;

  assign adr_in = wb_adr_i[21:1];
  assign take   = wb_cyc_i && wb_stb_i && !ack_q;  // one transfer at a time

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q  <= 1'b0;
      adr_q  <= '0;
      ctrl_q <= '0;
    end else begin
      ack_q <= take;
      if (take) begin
        adr_q <= adr_in;
        if (wb_we_i) begin
          case (adr_in)
            dram_th_regs_pkg::REG_CTRL_0: begin
              if (wb_sel_i[0])
                ctrl_q[7:0] <= wb_dat_i[7:0];
              if (wb_sel_i[1])
                ctrl_q[15:8] <= wb_dat_i[15:8];
            end
            dram_th_regs_pkg::REG_CTRL_1: begin
              if (wb_sel_i[0])
                ctrl_q[23:16] <= wb_dat_i[7:0];
              if (wb_sel_i[1])
                ctrl_q[31:24] <= wb_dat_i[15:8];
            end
            dram_th_regs_pkg::REG_CTRL_2: begin
              if (wb_sel_i[0])
                ctrl_q[39:32] <= wb_dat_i[7:0];
              if (wb_sel_i[1])
                ctrl_q[45:40] <= wb_dat_i[13:8];  // only 6 bits live here
            end
            default: begin
              // other addresses are acked and dropped
            end
          endcase
        end
      end
    end
  end

  // read data follows the last accessed address
  always_comb begin
    case (adr_q)
      dram_th_regs_pkg::REG_CTRL_0: wb_dat_o = ctrl_q[15:0];
      dram_th_regs_pkg::REG_CTRL_1: wb_dat_o = ctrl_q[31:16];
      dram_th_regs_pkg::REG_CTRL_2: wb_dat_o = {2'b00, ctrl_q[45:32]};
      default:                      wb_dat_o = harness_status_i;
    endcase
  end

  assign wb_ack_o          = ack_q;
  assign status_addr_o     = adr_q[3:0];
  assign harness_control_o = ctrl_q;

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) wb_ack_o |=> !wb_ack_o)
    else $error("wb_ack_o held for two cycles");

endmodule

`default_nettype wire

/* source/dram_th_engine.sv */
`default_nettype none
`timescale 1ns/1ps

module dram_th_engine #(
  parameter int ADDR_W = 10
) (
  input  logic                          wb_clk_i,
  input  logic                          wb_rst_i,
  input  dram_th_regs_pkg::ctrl_word_t  harness_control_i,
  input  dram_th_test_pkg::status_idx_t status_addr_i,
  output dram_th_regs_pkg::wb_data_t    harness_status_o,
  output logic                          mem_we_o,
  output logic                          mem_re_o,
  output logic [ADDR_W-1:0]             mem_addr_o,
  output dram_th_regs_pkg::wb_data_t    mem_wdata_o,
  input  dram_th_regs_pkg::wb_data_t    mem_rdata_i,
  input  logic                          mem_rvalid_i
);

  typedef logic [ADDR_W-1:0] mem_addr_t;

  dram_th_test_pkg::pattern_t      ctl_seed;
  dram_th_regs_pkg::word_count_t   ctl_count;
  dram_th_test_pkg::pattern_mode_e ctl_mode;
  mem_addr_t                       ctl_base;
  logic                            ctl_start;
  logic                            ctl_inject;

  dram_th_test_pkg::engine_state_e state_q;
  dram_th_test_pkg::pattern_t      seed_q;
  dram_th_regs_pkg::word_count_t   count_q;
  dram_th_test_pkg::pattern_mode_e mode_q;
  mem_addr_t                       base_q;
  logic                            inject_q;
  logic                            start_q;
  mem_addr_t                       addr_q;
  dram_th_regs_pkg::word_count_t   idx_q;
  dram_th_test_pkg::pattern_t      gen_q;
  dram_th_test_pkg::pattern_t      pattern;

  logic                            start_go;
  logic                            last_word;
  logic                            busy;
  logic                            done;
  logic                            pass;

  // expected word queue, two deep
  dram_th_test_pkg::pattern_t      fifo_exp [2];
  mem_addr_t                       fifo_adr [2];
  logic                            fifo_wp_q;
  logic                            fifo_rp_q;
  logic [1:0]                      fifo_cnt_q;
  dram_th_test_pkg::pattern_t      exp_word;
  mem_addr_t                       exp_addr;

  dram_th_regs_pkg::wb_data_t      err_cnt_q;
  mem_addr_t                       err_addr_q;
  dram_th_regs_pkg::wb_data_t      err_read_q;
  dram_th_regs_pkg::wb_data_t      err_exp_q;

  assign ctl_seed   = harness_control_i[dram_th_regs_pkg::CTRL_SEED_LSB +:
                                        dram_th_regs_pkg::CTRL_SEED_W];
  assign ctl_count  = harness_control_i[dram_th_regs_pkg::CTRL_COUNT_LSB +:
                                        dram_th_regs_pkg::CTRL_COUNT_W];
  assign ctl_mode   = dram_th_test_pkg::pattern_mode_e'(
                        harness_control_i[dram_th_regs_pkg::CTRL_MODE_LSB +:
                                          dram_th_regs_pkg::CTRL_MODE_W]);
  assign ctl_base   = mem_addr_t'(harness_control_i[dram_th_regs_pkg::CTRL_BASE_LSB +:
                                                    dram_th_regs_pkg::CTRL_BASE_W]);
  assign ctl_start  = harness_control_i[dram_th_regs_pkg::CTRL_START_BIT];
  assign ctl_inject = harness_control_i[dram_th_regs_pkg::CTRL_INJECT_BIT];

  assign busy = (state_q == dram_th_test_pkg::WRITE) || (state_q == dram_th_test_pkg::READ) ||
                (state_q == dram_th_test_pkg::DRAIN);
  assign done = (state_q == dram_th_test_pkg::DONE);
  assign pass = done && (err_cnt_q == '0);

  assign start_go  = ctl_start && !start_q && !busy;  // rising edge, ignored mid-run
  assign last_word = (idx_q == count_q - 16'd1);

  always_comb begin
    case (mode_q)
      dram_th_test_pkg::PAT_SEED: pattern = seed_q;
      dram_th_test_pkg::PAT_ADDR: pattern = seed_q ^ dram_th_test_pkg::pattern_t'(addr_q);
      default:                    pattern = gen_q;
    endcase
  end

  assign mem_we_o    = (state_q == dram_th_test_pkg::WRITE);
  assign mem_re_o    = (state_q == dram_th_test_pkg::READ);
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = pattern ^ {15'd0, inject_q && (idx_q == '0)};  // first word lands on base

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q  <= dram_th_test_pkg::IDLE;
      start_q  <= 1'b0;
      seed_q   <= '0;
      count_q  <= '0;
      mode_q   <= dram_th_test_pkg::PAT_SEED;
      base_q   <= '0;
      inject_q <= 1'b0;
      addr_q   <= '0;
      idx_q    <= '0;
      gen_q    <= '0;
    end else begin
      start_q <= ctl_start;
      case (state_q)
        dram_th_test_pkg::IDLE, dram_th_test_pkg::DONE: begin
          if (start_go) begin
            seed_q   <= ctl_seed;
            count_q  <= ctl_count;
            mode_q   <= ctl_mode;
            base_q   <= ctl_base;
            inject_q <= ctl_inject;
            addr_q   <= ctl_base;
            idx_q    <= '0;
            gen_q    <= dram_th_test_pkg::pat_first(ctl_mode, ctl_seed);
            state_q  <= (ctl_count == '0) ? dram_th_test_pkg::DONE : dram_th_test_pkg::WRITE;
          end
        end
        dram_th_test_pkg::WRITE, dram_th_test_pkg::READ: begin
          addr_q <= addr_q + 1'b1;  // wraps at the top of memory
          idx_q  <= idx_q + 16'd1;
          gen_q  <= dram_th_test_pkg::pat_next(mode_q, gen_q);
          if (last_word) begin
            addr_q <= base_q;
            idx_q  <= '0;
            gen_q  <= dram_th_test_pkg::pat_first(mode_q, seed_q);
            if (state_q == dram_th_test_pkg::WRITE)
              state_q <= dram_th_test_pkg::READ;
            else
              state_q <= dram_th_test_pkg::DRAIN;
          end
        end
        dram_th_test_pkg::DRAIN: begin
          if (fifo_cnt_q == 2'd0)
            state_q <= dram_th_test_pkg::DONE;
        end
        default: state_q <= dram_th_test_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (mem_re_o) begin
      fifo_exp[fifo_wp_q] <= pattern;
      fifo_adr[fifo_wp_q] <= addr_q;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      fifo_wp_q  <= 1'b0;
      fifo_rp_q  <= 1'b0;
      fifo_cnt_q <= 2'd0;
    end else begin
      if (mem_re_o)
        fifo_wp_q <= !fifo_wp_q;
      if (mem_rvalid_i)
        fifo_rp_q <= !fifo_rp_q;
      fifo_cnt_q <= fifo_cnt_q + {1'b0, mem_re_o} - {1'b0, mem_rvalid_i};
    end
  end

  assign exp_word = fifo_exp[fifo_rp_q];
  assign exp_addr = fifo_adr[fifo_rp_q];

  // error recorder
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || start_go) begin
      err_cnt_q  <= '0;
      err_addr_q <= '0;
      err_read_q <= '0;
      err_exp_q  <= '0;
    end else if (mem_rvalid_i && (mem_rdata_i != exp_word)) begin
      if (err_cnt_q != '1)
        err_cnt_q <= err_cnt_q + 16'd1;  // saturates
      if (err_cnt_q == '0) begin
        err_addr_q <= exp_addr;
        err_read_q <= mem_rdata_i;
        err_exp_q  <= exp_word;
      end
    end
  end

  always_comb begin
    harness_status_o = '0;
    case (status_addr_i)
      dram_th_test_pkg::ST_FLAGS: begin
        harness_status_o[dram_th_test_pkg::FLAG_BUSY] = busy;
        harness_status_o[dram_th_test_pkg::FLAG_DONE] = done;
        harness_status_o[dram_th_test_pkg::FLAG_PASS] = pass;
      end
      dram_th_test_pkg::ST_ERRCNT:   harness_status_o = err_cnt_q;
      dram_th_test_pkg::ST_ERR_ADDR: harness_status_o = dram_th_regs_pkg::wb_data_t'(err_addr_q);
      dram_th_test_pkg::ST_ERR_READ: harness_status_o = err_read_q;
      dram_th_test_pkg::ST_ERR_EXP:  harness_status_o = err_exp_q;
      default:                       harness_status_o = '0;
    endcase
  end

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) !(mem_we_o && mem_re_o))
    else $error("memory write and read strobes overlap");

  // memory must never return more reads than were issued
  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) mem_rvalid_i |-> fifo_cnt_q != 2'd0)
    else $error("read data returned with no expected word queued");

endmodule

`default_nettype wire

/* source/dram_th_mem.sv */
`default_nettype none
`timescale 1ns/1ps

module dram_th_mem #(
  parameter int ADDR_W = 10
) (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,
  input  logic                       mem_we_i,
  input  logic                       mem_re_i,
  input  logic [ADDR_W-1:0]          mem_addr_i,
  input  dram_th_regs_pkg::wb_data_t mem_wdata_i,
  output dram_th_regs_pkg::wb_data_t mem_rdata_o,
  output logic                       mem_rvalid_o
);

  dram_th_regs_pkg::wb_data_t mem_q [2**ADDR_W];

  always_ff @(posedge wb_clk_i) begin
    if (mem_we_i)
      mem_q[mem_addr_i] <= mem_wdata_i;
    if (mem_re_i)
      mem_rdata_o <= mem_q[mem_addr_i];  // one cycle latency
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i)
      mem_rvalid_o <= 1'b0;
    else
      mem_rvalid_o <= mem_re_i;
  end

  assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                   mem_rvalid_o == $past(mem_re_i))
    else $error("mem_rvalid_o out of step with mem_re_i");

endmodule

`default_nettype wire

/* source/dram_th_regs_pkg.sv */
`default_nettype none

package dram_th_regs_pkg;

  typedef logic [15:0] wb_data_t;
  typedef logic [20:0] wb_word_adr_t;   // wb_adr_i[21:1]
  typedef logic [45:0] ctrl_word_t;
  typedef logic [15:0] word_count_t;

  // word addresses of the control registers
  localparam wb_word_adr_t REG_CTRL_0 = 21'h10;
  localparam wb_word_adr_t REG_CTRL_1 = 21'h11;
  localparam wb_word_adr_t REG_CTRL_2 = 21'h12;

  // field positions in ctrl_word_t
  localparam int CTRL_SEED_LSB   = 0;
  localparam int CTRL_SEED_W     = 16;
  localparam int CTRL_COUNT_LSB  = 16;
  localparam int CTRL_COUNT_W    = 16;
  localparam int CTRL_START_BIT  = 32;
  localparam int CTRL_MODE_LSB   = 33;
  localparam int CTRL_MODE_W     = 2;
  localparam int CTRL_INJECT_BIT = 35;
  localparam int CTRL_BASE_LSB   = 36;
  localparam int CTRL_BASE_W     = 10;   // start address

endpackage

`default_nettype wire

/* source/dram_th_test_pkg.sv */
`default_nettype none

package dram_th_test_pkg;

  typedef logic [15:0] pattern_t;
  typedef logic [3:0]  status_idx_t;

  typedef enum logic [1:0] {
    PAT_SEED = 2'd0,
    PAT_ADDR = 2'd1,
    PAT_LFSR = 2'd2,
    PAT_WALK = 2'd3
  } pattern_mode_e;

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    READ,
    DRAIN,
    DONE
  } engine_state_e;

  localparam status_idx_t ST_FLAGS    = 4'd0;
  localparam status_idx_t ST_ERRCNT   = 4'd1;
  localparam status_idx_t ST_ERR_ADDR = 4'd2;
  localparam status_idx_t ST_ERR_READ = 4'd3;
  localparam status_idx_t ST_ERR_EXP  = 4'd4;

  localparam int FLAG_BUSY = 0;
  localparam int FLAG_DONE = 1;
  localparam int FLAG_PASS = 2;

  // first word of a run
  function automatic pattern_t pat_first(pattern_mode_e mode, pattern_t seed);
    pattern_t one_hot;
    one_hot = 16'h0001 << seed[3:0];
    return (mode == PAT_WALK) ? one_hot : seed;
  endfunction

  function automatic pattern_t pat_next(pattern_mode_e mode, pattern_t cur);
    pattern_t nxt;
    case (mode)
      PAT_LFSR: nxt = {cur[14:0], cur[15] ^ cur[13] ^ cur[12] ^ cur[10]};  // taps 16,14,13,11
      PAT_WALK: nxt = {cur[14:0], cur[15]};
      default:  nxt = cur;
    endcase
    return nxt;
  endfunction

endpackage

`default_nettype wire

/* source/dram_th_top.sv */
`default_nettype none
`timescale 1ns/1ps

module dram_th_top #(
  parameter int ADDR_W = 10
) (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  logic [1:0]                 wb_sel_i,
  input  logic [31:0]                wb_adr_i,
  input  dram_th_regs_pkg::wb_data_t wb_dat_i,
  output dram_th_regs_pkg::wb_data_t wb_dat_o,
  output logic                       wb_ack_o
);

  dram_th_regs_pkg::ctrl_word_t harness_control;
  dram_th_regs_pkg::wb_data_t   harness_status;
  logic [3:0]                   status_addr;
  logic                         mem_we;
  logic                         mem_re;
  logic [ADDR_W-1:0]            mem_addr;
  dram_th_regs_pkg::wb_data_t   mem_wdata;
  dram_th_regs_pkg::wb_data_t   mem_rdata;
  logic                         mem_rvalid;

  dram_test_h_wb u_wb (
    .wb_clk_i          (wb_clk_i),
    .wb_rst_i          (wb_rst_i),
    .wb_we_i           (wb_we_i),
    .wb_cyc_i          (wb_cyc_i),
    .wb_stb_i          (wb_stb_i),
    .wb_sel_i          (wb_sel_i),
    .wb_adr_i          (wb_adr_i),
    .wb_dat_i          (wb_dat_i),
    .wb_dat_o          (wb_dat_o),
    .wb_ack_o          (wb_ack_o),
    .status_addr_o     (status_addr),
    .harness_status_i  (harness_status),
    .harness_control_o (harness_control)
  );

  dram_th_engine #(.ADDR_W(ADDR_W)) u_engine (
    .wb_clk_i          (wb_clk_i),
    .wb_rst_i          (wb_rst_i),
    .harness_control_i (harness_control),
    .status_addr_i     (status_addr),
    .harness_status_o  (harness_status),
    .mem_we_o          (mem_we),
    .mem_re_o          (mem_re),
    .mem_addr_o        (mem_addr),
    .mem_wdata_o       (mem_wdata),
    .mem_rdata_i       (mem_rdata),
    .mem_rvalid_i      (mem_rvalid)
  );

  dram_th_mem #(.ADDR_W(ADDR_W)) u_mem (  // stands in for the DDR2 controller
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .mem_we_i     (mem_we),
    .mem_re_i     (mem_re),
    .mem_addr_i   (mem_addr),
    .mem_wdata_i  (mem_wdata),
    .mem_rdata_o  (mem_rdata),
    .mem_rvalid_o (mem_rvalid)
  );

endmodule

`default_nettype wire

/* tests/dram_th_stimulus.txt */
# op word_adr data sel expected (hex; word_adr is wb_adr_i[21:1])
# W write, R read and compare, P poll ST_FLAGS until done (data = word count)
R 00 0000 3 0000
R 01 0000 3 0000
R 05 0000 3 0000
R 1f 0000 3 0000
W 20 ffff 3 0000
R 10 0000 3 0000
# control registers with byte lanes
W 10 1234 3 0000
W 10 abcd 1 0000
W 11 5678 2 0000
W 11 9a9a 1 0000
W 12 fffe 3 0000
R 10 0000 3 12cd
R 11 0000 3 569a
R 12 0000 3 3ffe
W 12 c1ff 2 0000
R 12 0000 3 01fe
# clean runs: seed, addr, lfsr, walk
W 10 a5a5 3 0000
W 11 0010 3 0000
W 12 0000 3 0000
W 12 0001 3 0000
P 00 0010 3 0006
R 01 0000 3 0000
W 10 0f0f 3 0000
W 11 0020 3 0000
W 12 0402 3 0000
W 12 0403 3 0000
P 00 0020 3 0006
R 01 0000 3 0000
W 10 ace1 3 0000
W 11 0040 3 0000
W 12 1004 3 0000
W 12 1005 3 0000
P 00 0040 3 0006
R 01 0000 3 0000
W 10 0007 3 0000
W 11 0018 3 0000
W 12 2006 3 0000
W 12 2007 3 0000
P 00 0018 3 0006
R 01 0000 3 0000
# injected error, addr mode at base 080 expects 5a5a ^ 0080
W 10 5a5a 3 0000
W 11 0008 3 0000
W 12 080a 3 0000
W 12 080b 3 0000
P 00 0008 3 0002
R 01 0000 3 0001
R 02 0000 3 0080
R 03 0000 3 5adb
R 04 0000 3 5ada
# zero count restarts and clears the error record
W 11 0000 3 0000
W 12 0000 3 0000
W 12 0001 3 0000
P 00 0000 3 0006
R 01 0000 3 0000
R 02 0000 3 0000
# lfsr window from 3f8 wraps past the top of memory
W 10 1234 3 0000
W 11 0010 3 0000
W 12 3f84 3 0000
W 12 3f85 3 0000
P 00 0010 3 0006
R 01 0000 3 0000

/* tests/dram_th_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module dram_th_tb;

  localparam string STIM_FILE = "tests/dram_th_stimulus.txt";
  localparam int    ACK_LIMIT = 16;  // cycles allowed from strobe to ack

  logic                       wb_clk_i;
  logic                       wb_rst_i;
  logic                       wb_cyc_i;
  logic                       wb_stb_i;
  logic                       wb_we_i;
  logic [1:0]                 wb_sel_i;
  logic [31:0]                wb_adr_i;
  dram_th_regs_pkg::wb_data_t wb_dat_i;
  dram_th_regs_pkg::wb_data_t wb_dat_o;
  logic                       wb_ack_o;

  // one entry per stimulus line
  logic [7:0]  ops       [$];
  logic [31:0] word_adrs [$];
  logic [31:0] wr_data   [$];
  logic [31:0] sels      [$];
  logic [31:0] expects   [$];

  int unsigned cycle_cnt;
  int unsigned wd_cycles;

  dram_th_top #(.ADDR_W(10)) DUT (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_sel_i (wb_sel_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  always #5 wb_clk_i = ~wb_clk_i;

  always @(posedge wb_clk_i)
    cycle_cnt <= cycle_cnt + 1;

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%04h, expected 0x%04h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic read_stimulus();
    int          fd;
    int          code;
    string       line;
    logic [7:0]  op;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] sel;
    logic [31:0] exp;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", STIM_FILE);
      $display("SIMULATION FAILED");
      $fatal(1, "no stimulus");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
          code = $sscanf(line, "%c %h %h %h %h", op, adr, dat, sel, exp);
          if (code != 5) begin
            $display("malformed stimulus line: %s", line);
            $display("SIMULATION FAILED");
            $fatal(1, "bad stimulus");
          end else begin
            ops.push_back(op);
            word_adrs.push_back(adr);
            wr_data.push_back(dat);
            sels.push_back(sel);
            expects.push_back(exp);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // strobe held until ack and read data taken while ack is high
  task automatic wb_transfer(input logic we, input logic [20:0] word_adr,
                             input logic [15:0] dat, input logic [1:0] sel,
                             output logic [15:0] rdata);
    int unsigned waited;
    waited = 0;
    rdata  = '0;
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= {10'd0, word_adr, 1'b0};
    wb_dat_i <= dat;
    wb_sel_i <= sel;
    @(negedge wb_clk_i);
    while (!wb_ack_o && waited < ACK_LIMIT) begin
      @(negedge wb_clk_i);
      waited++;
    end
    if (!wb_ack_o) begin
      $display("no wb_ack_o within %0d cycles of a strobe", ACK_LIMIT);
      $display("SIMULATION FAILED");
      $fatal(1, "bus transfer timed out");
    end else begin
      rdata = wb_dat_o;
      @(posedge wb_clk_i);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
    end
  endtask

  task automatic poll_done(input int unsigned count, input logic [15:0] exp);
    logic [15:0] flags;
    int unsigned limit;
    int unsigned t0;
    limit = count * 3 + 40;  // write, read and drain plus poll slack
    t0    = cycle_cnt;
    flags = '0;
    while (!flags[dram_th_test_pkg::FLAG_DONE] && (cycle_cnt - t0) < limit)
      wb_transfer(1'b0, 21'h0, 16'h0, 2'b11, flags);  // word 0 is ST_FLAGS
    if (!flags[dram_th_test_pkg::FLAG_DONE]) begin
      $display("engine did not report done within %0d cycles", limit);
      $display("SIMULATION FAILED");
      $fatal(1, "poll limit reached");
    end else begin
      check_value("st_flags", flags, exp);
    end
  endtask

  task automatic run_op(input int i);
    logic [15:0] rdata;
    case (ops[i])
      "W": wb_transfer(1'b1, word_adrs[i][20:0], wr_data[i][15:0], sels[i][1:0], rdata);
      "R": begin
        wb_transfer(1'b0, word_adrs[i][20:0], 16'h0, sels[i][1:0], rdata);
        check_value($sformatf("wb_dat_o at word 0x%0h", word_adrs[i]), rdata,
                    expects[i][15:0]);
      end
      "P": poll_done(wr_data[i], expects[i][15:0]);
      default: begin
        $display("unknown opcode in stimulus entry %0d", i);
        $display("SIMULATION FAILED");
        $fatal(1, "bad opcode");
      end
    endcase
  endtask

  initial begin
    int unsigned total_count;
    wb_clk_i    = 1'b0;
    wb_rst_i    = 1'b1;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_sel_i    = 2'b00;
    wb_adr_i    = '0;
    wb_dat_i    = '0;
    cycle_cnt   = 0;
    wd_cycles   = 0;
    total_count = 0;
    read_stimulus();
    foreach (ops[i])
      if (ops[i] == "P")
        total_count += wr_data[i];
    wd_cycles = ops.size() * 4 + total_count * 3 + 200;
    repeat (3) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    foreach (ops[i])
      run_op(i);
    repeat (2) @(posedge wb_clk_i);
    $display("SIMULATION PASSED");
    $finish;
  end

  // watchdog armed once the stimulus is loaded
  initial begin
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge wb_clk_i);
    $display("watchdog expired after %0d cycles", wd_cycles);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

/* vlog.f */
source/dram_th_regs_pkg.sv
source/dram_th_test_pkg.sv
source/dram_test_h_wb.sv
source/dram_th_engine.sv
source/dram_th_mem.sv
source/dram_th_top.sv
tests/dram_th_tb.sv
